/* verilog/tpu_params.svh */
// build-time constants; MM_DIM fixed at 4, bus halves and status layout assume that value
`ifndef TPU_PARAMS_SVH
`define TPU_PARAMS_SVH

// ==================================================
// array geometry and widths
// ==================================================
`define MM_DIM      4
`define MM_IN_W     8
`define MM_ACC_W    16
`define BUS_ADDR_W  10
`define BUS_DATA_W  32
`define MEM_DEPTH   256

// address bits 9:8
`define REGION_CONTROL 2'd0
`define REGION_INPUT   2'd1
`define REGION_WEIGHT  2'd2
`define REGION_OUTPUT  2'd3

// write data bits 3:0 of a control write
`define OP_RESET    4'd15
`define OP_FILL     4'd1
`define OP_DRAIN    4'd2
`define OP_MULTIPLY 4'd3

`endif

/* verilog/tpu_pkg.sv */
// row and tile types for the accelerator; element 0 always sits in the low bits
`include "tpu_params.svh"

package tpu_pkg;

    // four unsigned operands, element 0 in the low byte
    typedef logic [`MM_DIM-1:0][`MM_IN_W-1:0] operand_row_t;

    // four wrapping sums, element 0 in the low half-word
    typedef logic [`MM_DIM-1:0][`MM_ACC_W-1:0] result_row_t;

    // staging buffer and array weight load, row i is weight row i
    typedef operand_row_t [`MM_DIM-1:0] weight_tile_t;

    // one-cycle command pulse from the bus slave
    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_RESET,
        CMD_FILL,
        CMD_DRAIN,
        CMD_MULTIPLY
    } mm_cmd_e;

endpackage

/* verilog/tile_memory.sv */
// simple dual-port RAM, one write and one registered read; contents are not reset
`timescale 1ns/1ns
`include "tpu_params.svh"

module tile_memory #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = `MEM_DEPTH
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  word_t                    wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output word_t                    rd_data
);

    word_t mem [0:DEPTH-1];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, one cycle latency, old data on a same-address collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* verilog/mm_bus_slave.sv */
// bus slave without wait states or byte enables; readdata is valid one cycle after the read strobe
`timescale 1ns/1ns
`include "tpu_params.svh"

module mm_bus_slave (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`BUS_ADDR_W-1:0]    address,
    input  logic                      write,
    input  logic                      read,
    input  logic [`BUS_DATA_W-1:0]    writedata,
    input  tpu_pkg::result_row_t      output_rd_data,
    input  logic                      output_done,
    input  logic                      weights_loaded,
    input  logic                      weights_staged,
    output logic [`BUS_DATA_W-1:0]    readdata,
    output logic                      input_wr_en,
    output logic                      weight_wr_en,
    output logic [7:0]                mem_wr_addr,
    output tpu_pkg::operand_row_t     mem_wr_data,
    output logic [7:0]                output_rd_addr,
    output tpu_pkg::mm_cmd_e          cmd,
    output logic [7:0]                weight_base,
    output logic [7:0]                input_base,
    output logic [6:0]                output_base
);

    logic [1:0] region;
    logic       ctrl_wr;
    logic [1:0] rd_region_q;
    logic       half_q;
    logic [2:0] status_q;
    logic [7:0] rd_row_q;

    // ==================================================
    // write side
    // ==================================================
    assign region       = address[9:8];
    assign ctrl_wr      = write && (region == `REGION_CONTROL);
    assign input_wr_en  = write && (region == `REGION_INPUT);
    assign weight_wr_en = write && (region == `REGION_WEIGHT);
    assign mem_wr_addr  = address[7:0];
    assign mem_wr_data  = writedata;

    // opcode decode, unknown codes fall through to none
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd <= tpu_pkg::CMD_NONE;
        end else begin
            cmd <= tpu_pkg::CMD_NONE;
            if (ctrl_wr) begin
                case (writedata[3:0])
                    `OP_RESET:    cmd <= tpu_pkg::CMD_RESET;
                    `OP_FILL:     cmd <= tpu_pkg::CMD_FILL;
                    `OP_DRAIN:    cmd <= tpu_pkg::CMD_DRAIN;
                    `OP_MULTIPLY: cmd <= tpu_pkg::CMD_MULTIPLY;
                    default:      cmd <= tpu_pkg::CMD_NONE;
                endcase
            end
        end
    end

    // bases ride along with their command
    always_ff @(posedge clk) begin
        if (ctrl_wr && writedata[3:0] == `OP_FILL) begin
            weight_base <= writedata[11:4];
        end
        if (ctrl_wr && writedata[3:0] == `OP_MULTIPLY) begin
            input_base  <= writedata[11:4];
            output_base <= writedata[18:12];
        end
    end

    // ==================================================
    // read side
    // ==================================================
    // hold last output row address so the data stays put between reads
    assign output_rd_addr = (read && region == `REGION_OUTPUT) ? {1'b0, address[7:1]} : rd_row_q;

    always_ff @(posedge clk) begin
        if (read && region == `REGION_OUTPUT) begin
            rd_row_q <= {1'b0, address[7:1]};
        end
    end

    // select info registered in step with the memory read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_region_q <= `REGION_CONTROL;
            half_q      <= 1'b0;
            status_q    <= '0;
        end else if (read) begin
            rd_region_q <= region;
            half_q      <= address[0];
            status_q    <= {output_done, weights_loaded, weights_staged};
        end
    end

    always_comb begin
        case (rd_region_q)
            `REGION_CONTROL: readdata = {29'd0, status_q};
            // half 1 carries elements 2 and 3
            `REGION_OUTPUT:  readdata = half_q ? {output_rd_data[3], output_rd_data[2]}
                                               : {output_rd_data[1], output_rd_data[0]};
            default:         readdata = '0;
        endcase
    end

endmodule

/* verilog/mm_sequencer.sv */
// phase controller; commands during a busy phase are dropped, OP_RESET always aborts
`timescale 1ns/1ns
`include "tpu_params.svh"

module mm_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  tpu_pkg::mm_cmd_e       cmd,
    input  logic [7:0]             weight_base,
    input  logic [7:0]             input_base,
    input  logic [6:0]             output_base,
    input  tpu_pkg::operand_row_t  weight_rd_data,
    input  tpu_pkg::operand_row_t  input_rd_data,
    input  tpu_pkg::result_row_t   result_row,
    input  logic                   result_valid,
    output logic [7:0]             weight_rd_addr,
    output logic [7:0]             input_rd_addr,
    output logic                   output_wr_en,
    output logic [7:0]             output_wr_addr,
    output tpu_pkg::result_row_t   output_wr_data,
    output tpu_pkg::weight_tile_t  weight_tile,
    output logic                   load_weights,
    output tpu_pkg::operand_row_t  row,
    output logic                   row_valid,
    output logic                   output_done,
    output logic                   weights_loaded,
    output logic                   weights_staged
);

    typedef enum logic [1:0] {S_IDLE, S_FILL, S_DRAIN, S_MULT} state_t;

    localparam int CNT_W = $clog2(`MM_DIM) + 1;

    state_t           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] res_cnt_q;
    logic [7:0]       rd_base_q;
    logic [6:0]       out_base_q;
    logic             issue;
    logic             row_valid_q;
    logic             wipe_q;

    // ==================================================
    // datapath hookup
    // ==================================================
    // one base register serves fill and multiply, never both at once
    assign issue          = cnt_q < CNT_W'(`MM_DIM);
    assign weight_rd_addr = rd_base_q + 8'(cnt_q);
    assign input_rd_addr  = rd_base_q + 8'(cnt_q);
    assign row            = input_rd_data;
    assign row_valid      = row_valid_q;
    assign output_wr_en   = result_valid && (state_q == S_MULT);
    assign output_wr_addr = {1'b0, out_base_q} + 8'(res_cnt_q);
    assign output_wr_data = result_row;
    // drain loads staged tile, wipe loads the cleared one
    assign load_weights   = (state_q == S_DRAIN) || wipe_q;

    // ==================================================
    // phase FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q        <= S_IDLE;
            cnt_q          <= '0;
            res_cnt_q      <= '0;
            row_valid_q    <= 1'b0;
            wipe_q         <= 1'b0;
            output_done    <= 1'b0;
            weights_loaded <= 1'b0;
            weights_staged <= 1'b0;
        end else begin
            row_valid_q <= 1'b0;
            wipe_q      <= 1'b0;
            if (cmd == tpu_pkg::CMD_RESET) begin
                state_q        <= S_IDLE;
                wipe_q         <= 1'b1;
                output_done    <= 1'b0;
                weights_loaded <= 1'b0;
                weights_staged <= 1'b0;
            end else begin
                case (state_q)
                    S_IDLE: begin
                        cnt_q     <= '0;
                        res_cnt_q <= '0;
                        // each phase clears its own done flag on entry
                        case (cmd)
                            tpu_pkg::CMD_FILL: begin
                                state_q        <= S_FILL;
                                weights_staged <= 1'b0;
                            end
                            tpu_pkg::CMD_DRAIN: begin
                                state_q        <= S_DRAIN;
                                weights_loaded <= 1'b0;
                            end
                            tpu_pkg::CMD_MULTIPLY: begin
                                state_q     <= S_MULT;
                                output_done <= 1'b0;
                            end
                            default: state_q <= S_IDLE;
                        endcase
                    end
                    S_FILL: begin
                        // last row lands while cnt sits at MM_DIM
                        cnt_q <= cnt_q + 1'b1;
                        if (!issue) begin
                            weights_staged <= 1'b1;
                            state_q        <= S_IDLE;
                        end
                    end
                    S_DRAIN: begin
                        weights_loaded <= 1'b1;
                        weights_staged <= 1'b0;
                        state_q        <= S_IDLE;
                    end
                    default: begin
                        // multiply, reads go out back to back
                        if (issue) begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                        row_valid_q <= issue;
                        if (result_valid) begin
                            res_cnt_q <= res_cnt_q + 1'b1;
                            if (res_cnt_q == CNT_W'(`MM_DIM - 1)) begin
                                output_done <= 1'b1;
                                state_q     <= S_IDLE;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // bases latched at command start, host may rewrite them meanwhile
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && cmd == tpu_pkg::CMD_FILL) begin
            rd_base_q <= weight_base;
        end
        if (state_q == S_IDLE && cmd == tpu_pkg::CMD_MULTIPLY) begin
            rd_base_q  <= input_base;
            out_base_q <= output_base;
        end
    end

    // staging tile, row k arrives one cycle after its read
    always_ff @(posedge clk) begin
        if (!rst_n || cmd == tpu_pkg::CMD_RESET) begin
            weight_tile <= '0;
        end else if (state_q == S_FILL && cnt_q != '0) begin
            weight_tile[cnt_q - 1'b1] <= weight_rd_data;
        end
    end

endmodule

/* verilog/systolic_array.sv */
// weight-stationary MM_DIM x MM_DIM array, unsigned, sums wrap; latency 2*MM_DIM, one row per cycle
`timescale 1ns/1ns
`include "tpu_params.svh"

module systolic_array (
    input  logic                   clk,
    input  logic                   rst_n,
    input  tpu_pkg::weight_tile_t  weight_tile,
    input  logic                   load_weights,
    input  tpu_pkg::operand_row_t  row,
    input  logic                   row_valid,
    output tpu_pkg::result_row_t   result_row,
    output logic                   result_valid
);

    tpu_pkg::weight_tile_t w_q;
    logic [2*`MM_DIM-1:0]  vld_q;
    logic [`MM_IN_W-1:0]   skew_out [0:`MM_DIM-1];
    logic [`MM_IN_W-1:0]   opnd_q   [0:`MM_DIM-1][0:`MM_DIM-2];
    logic [`MM_ACC_W-1:0]  psum_q   [0:`MM_DIM-1][0:`MM_DIM-1];

    // stationary weights and the valid pipe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_q   <= '0;
            vld_q <= '0;
        end else begin
            if (load_weights) begin
                w_q <= weight_tile;
            end
            vld_q <= {vld_q[2*`MM_DIM-2:0], row_valid};
        end
    end

    assign result_valid = vld_q[2*`MM_DIM-1];

    genvar i, j;

    // ==================================================
    // input skew, element i delayed i+1 cycles
    // ==================================================
    for (i = 0; i < `MM_DIM; i++) begin : g_skew
        logic [`MM_IN_W-1:0] sr [0:i];
        always_ff @(posedge clk) begin
            sr[0] <= row[i];
            for (int k = 1; k <= i; k++) begin
                sr[k] <= sr[k-1];
            end
        end
        assign skew_out[i] = sr[i];
    end

    // ==================================================
    // PE grid, operand moves right, psum moves down
    // ==================================================
    for (i = 0; i < `MM_DIM; i++) begin : g_row
        for (j = 0; j < `MM_DIM; j++) begin : g_col
            logic [`MM_IN_W-1:0]  a_in;
            logic [`MM_ACC_W-1:0] p_in;
            if (j == 0) begin : g_a_edge
                assign a_in = skew_out[i];
            end else begin : g_a_pass
                assign a_in = opnd_q[i][j-1];
            end
            // top row starts from zero
            if (i == 0) begin : g_p_top
                assign p_in = '0;
            end else begin : g_p_pass
                assign p_in = psum_q[i-1][j];
            end
            always_ff @(posedge clk) begin
                psum_q[i][j] <= p_in + a_in * w_q[i][j];
            end
            // rightmost column has nowhere to pass to
            if (j < `MM_DIM - 1) begin : g_fwd
                always_ff @(posedge clk) begin
                    opnd_q[i][j] <= a_in;
                end
            end
        end
    end

    // ==================================================
    // output deskew, column j waits MM_DIM-1-j cycles
    // ==================================================
    for (j = 0; j < `MM_DIM; j++) begin : g_deskew
        if (j == `MM_DIM - 1) begin : g_direct
            assign result_row[j] = psum_q[`MM_DIM-1][j];
        end else begin : g_delay
            logic [`MM_ACC_W-1:0] dr [0:`MM_DIM-2-j];
            always_ff @(posedge clk) begin
                dr[0] <= psum_q[`MM_DIM-1][j];
                for (int k = 1; k <= `MM_DIM - 2 - j; k++) begin
                    dr[k] <= dr[k-1];
                end
            end
            assign result_row[j] = dr[`MM_DIM-2-j];
        end
    end

endmodule

/* verilog/mm_accel_top.sv */
// accelerator top; bus has no wait states, host must poll status before reading results
`timescale 1ns/1ns
`include "tpu_params.svh"

module mm_accel_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`BUS_ADDR_W-1:0] address,
    input  logic                   write,
    input  logic                   read,
    input  logic [`BUS_DATA_W-1:0] writedata,
    output logic [`BUS_DATA_W-1:0] readdata
);

    // bus side
    logic                  input_wr_en;
    logic                  weight_wr_en;
    logic [7:0]            mem_wr_addr;
    tpu_pkg::operand_row_t mem_wr_data;
    logic [7:0]            output_rd_addr;
    tpu_pkg::result_row_t  output_rd_data;
    tpu_pkg::mm_cmd_e      cmd;
    logic [7:0]            weight_base;
    logic [7:0]            input_base;
    logic [6:0]            output_base;
    // sequencer side
    logic [7:0]            weight_rd_addr;
    logic [7:0]            input_rd_addr;
    tpu_pkg::operand_row_t weight_rd_data;
    tpu_pkg::operand_row_t input_rd_data;
    logic                  output_wr_en;
    logic [7:0]            output_wr_addr;
    tpu_pkg::result_row_t  output_wr_data;
    tpu_pkg::weight_tile_t weight_tile;
    logic                  load_weights;
    tpu_pkg::operand_row_t row;
    logic                  row_valid;
    tpu_pkg::result_row_t  result_row;
    logic                  result_valid;
    logic                  output_done;
    logic                  weights_loaded;
    logic                  weights_staged;

    mm_bus_slave slave (
        .clk, .rst_n, .address, .write, .read, .writedata,
        .output_rd_data, .output_done, .weights_loaded, .weights_staged,
        .readdata, .input_wr_en, .weight_wr_en, .mem_wr_addr, .mem_wr_data,
        .output_rd_addr, .cmd, .weight_base, .input_base, .output_base
    );

    tile_memory #(.word_t(tpu_pkg::operand_row_t)) input_mem (
        .clk, .wr_en(input_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
        .rd_addr(input_rd_addr), .rd_data(input_rd_data)
    );

    tile_memory #(.word_t(tpu_pkg::operand_row_t)) weight_mem (
        .clk, .wr_en(weight_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
        .rd_addr(weight_rd_addr), .rd_data(weight_rd_data)
    );

    // written by the sequencer, read by the bus
    tile_memory #(.word_t(tpu_pkg::result_row_t)) output_mem (
        .clk, .wr_en(output_wr_en), .wr_addr(output_wr_addr), .wr_data(output_wr_data),
        .rd_addr(output_rd_addr), .rd_data(output_rd_data)
    );

    mm_sequencer sequencer (
        .clk, .rst_n, .cmd, .weight_base, .input_base, .output_base,
        .weight_rd_data, .input_rd_data, .result_row, .result_valid,
        .weight_rd_addr, .input_rd_addr, .output_wr_en, .output_wr_addr,
        .output_wr_data, .weight_tile, .load_weights, .row, .row_valid,
        .output_done, .weights_loaded, .weights_staged
    );

    systolic_array array (
        .clk, .rst_n, .weight_tile, .load_weights, .row, .row_valid,
        .result_row, .result_valid
    );

endmodule

/* tb/tb_clock.sv */
// free-running testbench clock, starts low, first rising edge at half a period
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

/* tb/mm_accel_properties.sv */
// bound into mm_accel_top; bus and done-flag checks only, samples on the rising clock edge
`timescale 1ns/1ns
`include "tpu_params.svh"

module mm_accel_properties (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   write,
    input logic                   read,
    input logic [`BUS_DATA_W-1:0] readdata,
    input tpu_pkg::mm_cmd_e       cmd,
    input logic                   output_done
);

    // count of failed assertions
    int   assert_errors = 0;
    logic mult_seen;

    // multiply seen since the last reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mult_seen <= 1'b0;
        end else if (cmd == tpu_pkg::CMD_MULTIPLY) begin
            mult_seen <= 1'b1;
        end
    end

    // ==================================================
    // assertions
    // ==================================================
    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(write && read))
        else begin
            assert_errors++;
            $error("write and read strobes high in the same cycle");
        end

    done_needs_multiply: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(output_done) |-> mult_seen)
        else begin
            assert_errors++;
            $error("output_done rose without a multiply command since reset");
        end

    // first cycle out of reset
    readdata_cleared: assert property (@(posedge clk)
        $rose(rst_n) |-> readdata == '0)
        else begin
            assert_errors++;
            $error("readdata not zero in the first cycle after reset");
        end

endmodule

/* tb/mm_accel_tb.sv */
// testbench for mm_accel_top; MM_DIM of 4 assumed, status polled with a 200-cycle limit per wait
`timescale 1ns/1ns
`include "tpu_params.svh"

module mm_accel_tb;

    localparam int ROW_W = `MM_DIM * `MM_IN_W;
    localparam int RES_W = `MM_DIM * `MM_ACC_W;

    logic                   clk;
    logic                   rst_n;
    logic [`BUS_ADDR_W-1:0] address;
    logic                   write;
    logic                   read;
    logic [`BUS_DATA_W-1:0] writedata;
    logic [`BUS_DATA_W-1:0] readdata;

    // reference model mirroring the memories and the weight path
    logic [ROW_W-1:0] input_rows  [0:`MEM_DEPTH-1];
    logic [ROW_W-1:0] weight_rows [0:`MEM_DEPTH-1];
    logic [RES_W-1:0] output_rows [0:127];
    logic [ROW_W-1:0] staged_rows [0:`MM_DIM-1];
    logic [ROW_W-1:0] loaded_rows [0:`MM_DIM-1];
    // done, loaded, staged
    logic [2:0]       status_model;
    int               errors;
    int               checks;
    int               tests;

    tb_clock #(.PERIOD(40)) clock_gen (.clk(clk));

    mm_accel_top uut (
        .clk, .rst_n, .address, .write, .read, .writedata, .readdata
    );

    bind mm_accel_top mm_accel_properties props (
        .clk, .rst_n, .write, .read, .readdata, .cmd, .output_done
    );

    // ==================================================
    // bus access tasks are entered 5 ns after a rising edge
    // ==================================================
    task automatic bus_write(input logic [`BUS_ADDR_W-1:0] addr, input logic [31:0] data);
        address   = addr;
        writedata = data;
        write     = 1'b1;
        @(posedge clk);
        #5;
        write = 1'b0;
        // idle cycle while a command pulse reaches the sequencer
        @(posedge clk);
        #5;
    endtask

    task automatic bus_read(input logic [`BUS_ADDR_W-1:0] addr, output logic [31:0] data);
        address = addr;
        read    = 1'b1;
        @(posedge clk);
        #5;
        read = 1'b0;
        // readdata registered on the edge after the strobe
        data = readdata;
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s: expected %h got %h", $time, name, exp, got);
        end
    endtask

    // poll one status bit until set or out of time
    task automatic wait_status(input int bit_idx);
        logic [31:0] word;
        int          cycles;
        word   = '0;
        cycles = 0;
        while (!word[bit_idx] && cycles < 200) begin
            bus_read({`REGION_CONTROL, 8'd0}, word);
            cycles++;
        end
        if (!word[bit_idx]) begin
            errors++;
            $display("ERROR t=%0t: status bit %0d still clear after %0d cycles",
                     $time, bit_idx, cycles);
        end
    endtask

    task automatic check_status();
        logic [31:0] word;
        bus_read({`REGION_CONTROL, 8'd0}, word);
        compare("status", {29'd0, status_model}, word);
    endtask

    // both halves of each row with element 0 in the low half-word
    task automatic check_output_rows(input int first, input int count);
        logic [31:0] word;
        logic [6:0]  row_addr;
        for (int r = first; r < first + count; r++) begin
            for (int h = 0; h < 2; h++) begin
                row_addr = 7'(r);
                bus_read({`REGION_OUTPUT, row_addr, 1'(h)}, word);
                compare($sformatf("readdata row %0d half %0d", r, h),
                        output_rows[r][32*h +: 32], word);
            end
        end
    endtask

    // ==================================================
    // stimulus and model updates
    // ==================================================
    task automatic write_rows(input logic [1:0] region, input int base);
        logic [31:0] data;
        for (int k = 0; k < `MM_DIM; k++) begin
            data = $urandom;
            if (region == `REGION_WEIGHT) begin
                weight_rows[base+k] = data;
            end else begin
                input_rows[base+k] = data;
            end
            bus_write({region, 8'(base + k)}, data);
        end
    endtask

    task automatic issue_command(input logic [3:0] op, input int base, input int out_base);
        bus_write({`REGION_CONTROL, 8'd0}, {13'd0, 7'(out_base), 8'(base), op});
    endtask

    // sum over i of in[i] * w[i][j] kept to 16 bits
    function automatic logic [RES_W-1:0] expected_row(input logic [ROW_W-1:0] in_row);
        logic [RES_W-1:0]     res;
        logic [`MM_ACC_W-1:0] acc;
        res = '0;
        for (int j = 0; j < `MM_DIM; j++) begin
            acc = '0;
            for (int i = 0; i < `MM_DIM; i++) begin
                acc = acc + 16'(in_row[8*i +: 8]) * 16'(loaded_rows[i][8*j +: 8]);
            end
            res[16*j +: 16] = acc;
        end
        return res;
    endfunction

    task automatic run_fill(input int base);
        issue_command(`OP_FILL, base, 0);
        wait_status(0);
        for (int k = 0; k < `MM_DIM; k++) begin
            staged_rows[k] = weight_rows[base+k];
        end
        status_model[0] = 1'b1;
    endtask

    task automatic run_drain();
        issue_command(`OP_DRAIN, 0, 0);
        wait_status(1);
        for (int k = 0; k < `MM_DIM; k++) begin
            loaded_rows[k] = staged_rows[k];
        end
        status_model[1:0] = 2'b10;
    endtask

    task automatic run_multiply(input int in_base, input int out_base);
        issue_command(`OP_MULTIPLY, in_base, out_base);
        wait_status(2);
        for (int r = 0; r < `MM_DIM; r++) begin
            output_rows[out_base+r] = expected_row(input_rows[in_base+r]);
        end
        status_model[2] = 1'b1;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        end
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        int err_start;
        address      = '0;
        write        = 1'b0;
        read         = 1'b0;
        writedata    = '0;
        rst_n        = 1'b0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        status_model = '0;
        void'($urandom(89));
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;

        err_start = errors;
        check_status();
        finish_test("status after reset", err_start);

        err_start = errors;
        write_rows(`REGION_WEIGHT, 0);
        write_rows(`REGION_INPUT, 0);
        run_fill(0);
        check_status();
        run_drain();
        check_status();
        run_multiply(0, 0);
        check_status();
        check_output_rows(0, 4);
        finish_test("full flow at base 0", err_start);

        err_start = errors;
        write_rows(`REGION_WEIGHT, 16);
        write_rows(`REGION_INPUT, 40);
        run_fill(16);
        run_drain();
        run_multiply(40, 20);
        check_output_rows(20, 4);
        check_output_rows(0, 4);
        finish_test("nonzero bases", err_start);

        // two multiplies on one drain
        err_start = errors;
        write_rows(`REGION_INPUT, 60);
        write_rows(`REGION_INPUT, 64);
        run_multiply(60, 30);
        run_multiply(64, 40);
        check_output_rows(30, 4);
        check_output_rows(40, 4);
        finish_test("weight reuse", err_start);

        err_start = errors;
        run_fill(0);
        check_status();
        issue_command(4'd7, 0, 0);
        check_status();
        issue_command(`OP_RESET, 0, 0);
        status_model = '0;
        check_status();
        check_output_rows(0, 4);
        check_output_rows(20, 4);
        check_output_rows(30, 4);
        check_output_rows(40, 4);
        finish_test("reset and unknown opcode", err_start);

        $display("tests: %0d  checks: %0d  errors: %0d  assertion failures: %0d",
                 tests, checks, errors, uut.props.assert_errors);
        if (errors == 0 && uut.props.assert_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+verilog
verilog/tpu_pkg.sv
verilog/tile_memory.sv
verilog/mm_bus_slave.sv
verilog/mm_sequencer.sv
verilog/systolic_array.sv
verilog/mm_accel_top.sv
tb/tb_clock.sv
tb/mm_accel_properties.sv
tb/mm_accel_tb.sv

/* Bender.yml */
package:
  name: mm_accel

export_include_dirs:
  - verilog

sources:
  - verilog/tpu_pkg.sv
  - verilog/tile_memory.sv
  - verilog/mm_bus_slave.sv
  - verilog/mm_sequencer.sv
  - verilog/systolic_array.sv
  - verilog/mm_accel_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/mm_accel_properties.sv
      - tb/mm_accel_tb.sv
